//--- build.f
design/mp_mem_pkg.sv
design/bank_1r1w.sv
design/location_map.sv
design/write_steer.sv
design/read_port.sv
design/mp_mem_top.sv
dv/mp_mem_tb.sv

//--- design/bank_1r1w.sv
module bank_1r1w import mp_mem_pkg::*; (
  input  logic     clk,
  input  bank_wr_t wr,
  input  logic     rd_en,
  input  vrow_t    rd_row,
  output data_t    rd_data
);

  data_t mem [NUMVROW];

  // Write port
  always_ff @(posedge clk) begin
    if (wr.write) begin
      mem[wr.row] <= wr.din;
    end
  end

  // Registered read, old word on a same-row collision
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_row];
    end
  end

endmodule

//--- design/location_map.sv
module location_map import mp_mem_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  vrow_t    wr_row [NUMRUPT],
  input  vrow_t    rd_row [NUMRUPT],
  output map_row_t wr_ent [NUMRUPT],
  output map_row_t rd_ent [NUMRUPT],
  input  map_upd_t upd,
  output logic     ready
);

  map_row_t map_q [NUMVROW];
  vrow_t    sweep_row;
  map_row_t ident;
  map_row_t upd_row;

  // Identity entry: logical bank v in physical bank v, spare is free
  always_comb begin
    for (int v = 0; v < NUMVBNK; v++) begin
      ident.loc[v] = pbnk_t'(v);
    end
    ident.free = pbnk_t'(NUMPBNK - 1);
  end

  // Updated row: word moves to the new slot, its old slot becomes free
  always_comb begin
    upd_row                = map_q[upd.row];
    upd_row.loc[upd.vbnk]  = upd.slot;
    upd_row.free           = map_q[upd.row].loc[upd.vbnk];
  end

  // Start-up sweep over all rows
  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_row <= '0;
      ready     <= 1'b0;
    end else if (!ready) begin
      sweep_row <= sweep_row + 1'b1;
      if (sweep_row == vrow_t'(NUMVROW - 1)) begin
        ready <= 1'b1;  // Last row written
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!ready) begin
      map_q[sweep_row] <= ident;
    end else if (upd.en) begin
      map_q[upd.row] <= upd_row;
    end
  end

  // Lookups for both write rows and both read rows
  always_comb begin
    for (int i = 0; i < NUMRUPT; i++) begin
      wr_ent[i] = map_q[wr_row[i]];
      rd_ent[i] = map_q[rd_row[i]];
    end
  end

endmodule

//--- design/mp_mem_pkg.sv
package mp_mem_pkg;

  localparam int WIDTH   = 16;
  localparam int NUMRUPT = 2;
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMPBNK = 5;  // Bank 4 is the spare
  localparam int BITPBNK = 3;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;
  localparam int BITADDR = 6;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVBNK-1:0] vbnk_t;
  typedef logic [BITPBNK-1:0] pbnk_t;
  typedef logic [BITVROW-1:0] vrow_t;

  typedef struct packed {
    logic  read;
    logic  write;
    addr_t addr;
    data_t din;
  } port_req_t;

  typedef struct packed {
    logic  vld;
    data_t dout;
  } port_rsp_t;

  typedef struct packed {
    pbnk_t [NUMVBNK-1:0] loc;   // Slot of each logical word
    pbnk_t               free;  // Empty slot of the row
  } map_row_t;

  typedef struct packed {
    logic  write;
    vrow_t row;
    data_t din;
  } bank_wr_t;

  typedef struct packed {
    logic  en;
    vrow_t row;
    vbnk_t vbnk;
    pbnk_t slot;
  } map_upd_t;

  // Logical bank sits in the low address bits, row in the high bits
  function automatic vbnk_t addr_vbnk(addr_t addr);
    return addr[BITVBNK-1:0];
  endfunction

  function automatic vrow_t addr_row(addr_t addr);
    return addr[BITADDR-1:BITVBNK];
  endfunction

endpackage

//--- design/mp_mem_top.sv
module mp_mem_top import mp_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  port_req_t req [NUMRUPT],
  output port_rsp_t rsp [NUMRUPT],
  output logic      ready
);

  vrow_t    wr_row  [NUMRUPT];
  vrow_t    rd_row  [NUMRUPT];
  map_row_t wr_ent  [NUMRUPT];
  map_row_t rd_ent  [NUMRUPT];
  bank_wr_t bank_wr [NUMPBNK];
  map_upd_t upd;

  for (genvar i = 0; i < NUMRUPT; i++) begin : g_row
    assign wr_row[i] = addr_row(req[i].addr);
    assign rd_row[i] = addr_row(req[i].addr);
  end

  location_map u_map (
    .clk    (clk),
    .rst    (rst),
    .wr_row (wr_row),
    .rd_row (rd_row),
    .wr_ent (wr_ent),
    .rd_ent (rd_ent),
    .upd    (upd),
    .ready  (ready)
  );

  write_steer u_steer (
    .req     (req),
    .wr_ent  (wr_ent),
    .ready   (ready),
    .bank_wr (bank_wr),
    .upd     (upd)
  );

  // One bank replica set per read port
  for (genvar i = 0; i < NUMRUPT; i++) begin : g_port
    read_port u_rd (
      .clk     (clk),
      .rst     (rst),
      .req     (req[i]),
      .ent     (rd_ent[i]),
      .bank_wr (bank_wr),
      .ready   (ready),
      .rsp     (rsp[i])
    );
  end

endmodule

//--- design/read_port.sv
module read_port import mp_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  port_req_t req,
  input  map_row_t  ent,
  input  bank_wr_t  bank_wr [NUMPBNK],
  input  logic      ready,
  output port_rsp_t rsp
);

  vbnk_t rd_vbnk;
  vrow_t rd_row;
  pbnk_t rd_slot;
  logic  rd_go;
  data_t bank_dout [NUMPBNK];
  pbnk_t slot_q;
  logic  vld_q;

  assign rd_vbnk = addr_vbnk(req.addr);
  assign rd_row  = addr_row(req.addr);
  assign rd_slot = ent.loc[rd_vbnk];  // Physical bank holding the word
  assign rd_go   = ready & req.read;

  // Replica of every physical bank for this port
  for (genvar b = 0; b < NUMPBNK; b++) begin : g_bank
    logic bank_rd_en;

    assign bank_rd_en = rd_go & (rd_slot == pbnk_t'(b));

    bank_1r1w u_bank (
      .clk     (clk),
      .wr      (bank_wr[b]),
      .rd_en   (bank_rd_en),
      .rd_row  (rd_row),
      .rd_data (bank_dout[b])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_go;
    end
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk) begin
    if (rd_go) begin
      slot_q <= rd_slot;
    end
  end

  assign rsp.vld  = vld_q;
  assign rsp.dout = bank_dout[slot_q];

endmodule

//--- design/write_steer.sv
module write_steer import mp_mem_pkg::*; (
  input  port_req_t req     [NUMRUPT],
  input  map_row_t  wr_ent  [NUMRUPT],
  input  logic      ready,
  output bank_wr_t  bank_wr [NUMPBNK],
  output map_upd_t  upd
);

  vbnk_t              wr_vbnk  [NUMRUPT];
  vrow_t              wr_row   [NUMRUPT];
  pbnk_t              cur_slot [NUMRUPT];
  pbnk_t              dst_slot [NUMRUPT];
  logic [NUMRUPT-1:0] wr_en;
  logic               both_wr;
  logic               same_addr;
  logic               same_slot;
  logic               move;

  // Current slot of each written word
  always_comb begin
    for (int i = 0; i < NUMRUPT; i++) begin
      wr_vbnk[i]  = addr_vbnk(req[i].addr);
      wr_row[i]   = addr_row(req[i].addr);
      cur_slot[i] = wr_ent[i].loc[wr_vbnk[i]];
    end
  end

  // Conflict detection
  always_comb begin
    both_wr   = req[0].write & req[1].write;
    same_addr = both_wr & (req[0].addr == req[1].addr);
    same_slot = both_wr & (cur_slot[0] == cur_slot[1]);
    move      = same_slot & ~same_addr;  // Port 1 goes to the free slot
  end

  always_comb begin
    wr_en[0]    = ready & req[0].write & ~same_addr;  // Port 1 wins on equal address
    wr_en[1]    = ready & req[1].write;
    dst_slot[0] = cur_slot[0];
    dst_slot[1] = move ? wr_ent[1].free : cur_slot[1];
  end

  // One write command per physical bank
  always_comb begin
    for (int b = 0; b < NUMPBNK; b++) begin
      bank_wr[b] = '0;
      for (int i = 0; i < NUMRUPT; i++) begin
        if (wr_en[i] && dst_slot[i] == pbnk_t'(b)) begin
          bank_wr[b].write = 1'b1;
          bank_wr[b].row   = wr_row[i];
          bank_wr[b].din   = req[i].din;
        end
      end
    end
  end

  // Record the moved word
  always_comb begin
    upd.en   = ready & move;
    upd.row  = wr_row[1];
    upd.vbnk = wr_vbnk[1];
    upd.slot = wr_ent[1].free;
  end

endmodule

//--- dv/mp_mem_stim.txt
# test cmd0 addr0 data0 cmd1 addr1 data1 exp0 exp1
# cmd 0 idle, 1 read, 2 write; addr and data in hex; exp is checked only on reads
# Test 2: a written word reads back on both ports
2 2 01 1111 0 00 0000 0000 0000
2 1 01 0000 1 01 0000 1111 1111
2 2 3e 2222 2 05 3333 0000 0000
2 1 05 0000 1 3e 0000 3333 2222
2 0 00 0000 2 12 1212 0000 0000
2 1 12 0000 1 12 0000 1212 1212
# Test 3: same logical bank in different rows, port 1 moves to the spare
3 2 04 a004 2 08 b008 0000 0000
3 1 04 0000 1 08 0000 a004 b008
3 1 08 0000 1 04 0000 b008 a004
3 2 13 a013 2 23 b023 0000 0000
3 2 08 c008 2 0c d00c 0000 0000
3 1 13 0000 1 23 0000 a013 b023
3 1 08 0000 1 0c 0000 c008 d00c
# Test 4: conflict chain over rows 10 and 11, words rotate through all slots
4 2 28 4101 2 2c 4111 0000 0000
4 2 2d 4201 2 29 4211 0000 0000
4 2 2a 4301 2 2e 4311 0000 0000
4 2 2f 4401 2 2b 4411 0000 0000
4 2 28 4501 2 2e 4511 0000 0000
4 1 28 0000 1 2e 0000 4501 4511
4 2 2c 4601 2 29 4611 0000 0000
4 2 2b 4701 2 2d 4711 0000 0000
4 2 2f 4801 2 29 4811 0000 0000
4 1 29 0000 1 2d 0000 4811 4711
4 2 28 4901 2 2d 4911 0000 0000
4 2 2e 4a01 2 2a 4a11 0000 0000
4 1 28 0000 1 29 0000 4901 4811
4 1 2a 0000 1 2b 0000 4a11 4701
4 1 2c 0000 1 2d 0000 4601 4911
4 1 2e 0000 1 2f 0000 4a01 4801
# Test 5: both ports write one address, port 1 wins
5 2 30 5050 2 30 5151 0000 0000
5 1 30 0000 1 30 0000 5151 5151
5 2 31 5252 2 31 5353 0000 0000
5 1 31 0000 1 31 0000 5353 5353
# Test 6: read during a write sees the old word, the next read sees the new one
6 2 01 6666 1 01 0000 0000 1111
6 1 01 0000 1 01 0000 6666 6666
6 1 3e 0000 2 3e 7777 2222 0000
6 1 3e 0000 1 3e 0000 7777 7777
6 2 08 8888 1 08 0000 0000 c008
6 1 08 0000 1 08 0000 8888 8888

//--- dv/mp_mem_tb.sv
module mp_mem_tb import mp_mem_pkg::*; ();

  localparam int RDY_TIMEOUT   = 100;
  localparam int VLD_TIMEOUT   = 4;
  localparam int DRAIN_TIMEOUT = 20;
  localparam int DEPTH         = 8;

  // One read that still waits for its vld
  typedef struct packed {
    logic [7:0] test;
    addr_t      addr;
    data_t      exp;
  } pend_t;

  logic      clk;
  logic      rst;
  port_req_t req [NUMRUPT];
  port_rsp_t rsp [NUMRUPT];
  logic      ready;

  pend_t  pend   [NUMRUPT][DEPTH];
  int     wr_ptr [NUMRUPT] = '{0, 0};
  int     rd_ptr [NUMRUPT] = '{0, 0};
  int     age    [NUMRUPT] = '{0, 0};
  int     errors     = 0;
  int     checks     = 0;
  int     tests_pass = 0;
  int     tests_fail = 0;
  integer seed;

  mp_mem_top DUT (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .rsp   (rsp),
    .ready (ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  function automatic int pending(input int p);
    return wr_ptr[p] - rd_ptr[p];
  endfunction

  task automatic compare(input data_t exp, input data_t act, input string what);
    begin
      checks++;
      if (act !== exp) begin
        $display("mismatch at time %0t: %s expected %h got %h", $time, what, exp, act);
        errors++;
      end
    end
  endtask

  // Matches a vld pulse against the oldest outstanding read of a port
  task automatic check_port(input int p);
    pend_t head;
    begin
      if (rsp[p].vld === 1'b1) begin
        if (pending(p) == 0) begin
          $display("port %0d gave vld at time %0t with no read pending", p, $time);
          errors++;
        end else begin
          head = pend[p][rd_ptr[p] % DEPTH];
          compare(head.exp, rsp[p].dout,
                  $sformatf("test %0d port %0d addr %h", head.test, p, head.addr));
          rd_ptr[p]++;
          age[p] = 0;
        end
      end else if (pending(p) != 0) begin
        age[p]++;
        if (age[p] > VLD_TIMEOUT) begin
          $display("port %0d got no vld within %0d cycles for the read of address %h",
                   p, VLD_TIMEOUT, pend[p][rd_ptr[p] % DEPTH].addr);
          errors++;
          rd_ptr[p]++;  // Give up on this read
          age[p] = 0;
        end
      end
    end
  endtask

  always @(negedge clk) begin
    for (int p = 0; p < NUMRUPT; p++) begin
      check_port(p);
    end
  end

  task automatic drive_port(input int p, input int test, input int cmd,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] exp);
    port_req_t r;
    pend_t     ent;
    begin
      r       = '0;
      r.read  = (cmd == 1);
      r.write = (cmd == 2);
      r.addr  = addr[BITADDR-1:0];
      r.din   = data[WIDTH-1:0];
      req[p] <= r;
      if (cmd == 1) begin
        ent.test = 8'(test);
        ent.addr = r.addr;
        ent.exp  = exp[WIDTH-1:0];
        pend[p][wr_ptr[p] % DEPTH] = ent;
        wr_ptr[p]++;
      end
    end
  endtask

  task automatic drive_idle();
    begin
      for (int p = 0; p < NUMRUPT; p++) begin
        req[p] <= '0;
      end
    end
  endtask

  // Idles the ports until every outstanding read has been answered
  task automatic drain_reads();
    int cyc;
    begin
      cyc = 0;
      @(posedge clk);
      drive_idle();
      while ((pending(0) != 0 || pending(1) != 0) && cyc < DRAIN_TIMEOUT) begin
        @(posedge clk);
        cyc++;
      end
      if (pending(0) != 0 || pending(1) != 0) begin
        $display("reads still waiting for vld after %0d idle cycles", DRAIN_TIMEOUT);
        errors++;
      end
    end
  endtask

  task automatic finish_test(input int num, input int err_at_start);
    begin
      if (errors == err_at_start) begin
        tests_pass++;
        $display("test %0d passed", num);
      end else begin
        tests_fail++;
        $display("test %0d failed with %0d errors", num, errors - err_at_start);
      end
    end
  endtask

  task automatic run_stimulus();
    integer           fd;
    integer           n;
    integer           cnt;
    integer           gap;
    integer           cur_test;
    integer           test_err;
    integer           lines_run;
    integer           tn;
    integer           c0;
    integer           c1;
    logic [31:0]      a0;
    logic [31:0]      d0;
    logic [31:0]      a1;
    logic [31:0]      d1;
    logic [31:0]      e0;
    logic [31:0]      e1;
    logic [8*128-1:0] line;
    begin
      cur_test  = 0;
      test_err  = errors;
      lines_run = 0;
      fd = $fopen("dv/mp_mem_stim.txt", "r");
      if (fd == 0) begin
        $display("could not open the stimulus file dv/mp_mem_stim.txt");
        errors++;
      end else begin
        while (!$feof(fd)) begin
          line = '0;
          n = $fgets(line, fd);
          cnt = 0;
          if (n > 0) begin
            cnt = $sscanf(line, "%d %d %h %h %d %h %h %h %h",
                          tn, c0, a0, d0, c1, a1, d1, e0, e1);
          end
          if (cnt == 9) begin
            if (tn != cur_test) begin  // Test boundary
              if (cur_test != 0) begin
                drain_reads();
                finish_test(cur_test, test_err);
              end
              cur_test = tn;
              test_err = errors;
            end
            @(posedge clk);
            drive_port(0, tn, c0, a0, d0, e0);
            drive_port(1, tn, c1, a1, d1, e1);
            lines_run++;
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
              @(posedge clk);
              drive_idle();
            end
          end else if (cnt > 0) begin
            $display("malformed stimulus line with %0d fields", cnt);
            errors++;
          end
        end
        $fclose(fd);
        drain_reads();
        if (cur_test != 0) begin
          finish_test(cur_test, test_err);
        end
        if (lines_run == 0) begin
          $display("the stimulus file held no test lines");
          errors++;
        end
      end
    end
  endtask

  initial begin
    int        cyc;
    int        err_start;
    port_req_t sweep_rd;
    seed = 32'hadd8_b9ed;
    rst  = 1'b1;
    for (int p = 0; p < NUMRUPT; p++) begin
      req[p] = '0;
    end
    err_start = errors;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    sweep_rd      = '0;
    sweep_rd.read = 1'b1;
    for (int p = 0; p < NUMRUPT; p++) begin
      req[p] <= sweep_rd;  // Reads during the map sweep get no vld
    end
    repeat (NUMVROW) @(posedge clk);
    drive_idle();
    cyc = 0;
    while (ready !== 1'b1 && cyc < RDY_TIMEOUT) begin  // Map sweep in progress
      @(negedge clk);
      cyc++;
    end
    if (ready !== 1'b1) begin
      $display("ready never rose");
      errors++;
      finish_test(1, err_start);
    end else begin
      finish_test(1, err_start);
      run_stimulus();
    end
    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             tests_pass, tests_fail, checks, errors);
    if (errors == 0 && tests_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
